//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/cpu_alu.sv
// 8-bit alu
// add with carry, auxiliary carry and overflow, logic ops, increment,
// decrement and pass-through of the second operand

`timescale 1ns/100ps

module cpu_alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  byte_t   a,
    input  byte_t   b,
    input  byte_t   psw_in,
    output byte_t   result,
    output byte_t   psw_out
);

    logic [8:0] sum;
    logic [4:0] low_sum;    // nibble sum for the auxiliary carry

    assign sum     = {1'b0, a} + {1'b0, b};
    assign low_sum = {1'b0, a[3:0]} + {1'b0, b[3:0]};

    always_comb begin
        result  = b;
        psw_out = psw_in;   // flags kept unless add
        case (op)
            ALU_PASS_B: result = b;
            ALU_ADD: begin
                result          = sum[7:0];
                psw_out[PSW_CY] = sum[8];
                psw_out[PSW_AC] = low_sum[4];
                psw_out[PSW_OV] = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_INC: result = a + 8'd1;   // wraps at ff
            ALU_DEC: result = a - 8'd1;
            default: result = b;
        endcase
    end

endmodule

//--- logic/cpu_control.sv
// one-hot instruction sequencer
// steps nop, fetch, decode, rom/ram read, execute and ram write, counts the
// remaining steps of an instruction and registers the memory strobes

`timescale 1ns/100ps

module cpu_control import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    cpu_ctrl_if.cpu_control        ctrl,
    output logic                   mem_rd,
    output logic                   mem_wr,
    output logic                   mem_sel
);

    cpu_state_e state;
    cpu_state_e state_d;
    cpu_state_e dec_next;
    phase_t     run_phase;
    phase_t     run_phase_d;
    phase_t     phase_init;
    phase_t     nop_cnt;
    phase_t     nop_cnt_d;
    src_e       src_a;
    src_e       src_b;
    alu_op_e    alu_op;
    logic       acc_phase;     // high in the second cycle of an access
    logic       first_decode;
    logic       is_access;
    logic       step_done;

    assign first_decode = (state == ST_DECODE) && (run_phase == 4'd0);

    ins_decoder u_decoder (
        .instr        (ctrl.instr),
        .run_phase    (run_phase),
        .first_decode (first_decode),
        .phase_init   (phase_init),
        .next_state   (dec_next),
        .src_a        (src_a),
        .src_b        (src_b),
        .alu_op       (alu_op)
    );

    assign is_access = state inside {ST_FETCH, ST_ROM_RD, ST_RAM_RD, ST_RAM_WR};
    assign step_done = (state == ST_EXEC) || (is_access && acc_phase);

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d     = state;
        run_phase_d = run_phase;
        nop_cnt_d   = nop_cnt;
        case (state)
            ST_NOP: begin
                if (nop_cnt == 4'd0) begin
                    state_d   = ST_FETCH;
                    nop_cnt_d = NOP_CYCLES;   // ready for the next nop
                end else begin
                    nop_cnt_d = nop_cnt - 4'd1;
                end
            end
            ST_FETCH: begin
                run_phase_d = 4'd0;
                if (acc_phase)
                    state_d = ST_DECODE;
            end
            ST_DECODE: begin
                if (first_decode)
                    run_phase_d = phase_init;
                state_d = dec_next;
            end
            default: begin
                // one step finished, last one returns to fetch
                if (step_done) begin
                    run_phase_d = run_phase - 4'd1;
                    state_d     = (run_phase == 4'd1) ? ST_FETCH : ST_DECODE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_NOP;
            run_phase <= 4'd0;
            nop_cnt   <= NOP_CYCLES;
            acc_phase <= 1'b0;
            mem_rd    <= 1'b0;
            mem_wr    <= 1'b0;
            mem_sel   <= 1'b1;     // ram side when idle
        end else begin
            state     <= state_d;
            run_phase <= run_phase_d;
            nop_cnt   <= nop_cnt_d;
            acc_phase <= is_access && !acc_phase;
            // strobes follow the state being entered, high for both cycles
            mem_rd    <= state_d inside {ST_FETCH, ST_ROM_RD, ST_RAM_RD};
            mem_wr    <= (state_d == ST_RAM_WR);
            if (state_d inside {ST_RAM_RD, ST_RAM_WR})
                mem_sel <= 1'b1;
            else if (state_d inside {ST_FETCH, ST_ROM_RD})
                mem_sel <= 1'b0;
        end
    end

    assign ctrl.state      = state;
    assign ctrl.capture    = acc_phase;
    assign ctrl.exec_src_a = src_a;
    assign ctrl.exec_src_b = src_b;
    assign ctrl.alu_op     = alu_op;

    a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state));

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr));

endmodule

//--- logic/cpu_ctrl_if.sv
// sequencer to datapath control bundle
// state, access capture strobe and the decoded operand routing, with the
// instruction register returned to the decoder

`timescale 1ns/100ps

interface cpu_ctrl_if import cpu_pkg::*; ();

    cpu_state_e state;       // current sequencer state
    logic       capture;     // second cycle of an access state
    src_e       exec_src_a;  // destination or first operand
    src_e       exec_src_b;  // second operand or address source
    alu_op_e    alu_op;
    byte_t      instr;       // instruction register

    modport cpu_control (
        output state, capture, exec_src_a, exec_src_b, alu_op,
        input  instr
    );

    modport cpu_datapath (
        input  state, capture, exec_src_a, exec_src_b, alu_op,
        output instr
    );

endinterface

//--- logic/cpu_datapath.sv
// cpu datapath
// pc, ir, acc, b, psw and the ram/rom data registers, operand selection,
// special-function register handling and the registered memory bus

`timescale 1ns/100ps

module cpu_datapath import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  byte_t           data_in,
    cpu_ctrl_if.cpu_datapath ctrl,
    output addr_t           addr_bus,
    output byte_t           data_out
);

    addr_t pc, pc_d, addr_d;
    byte_t ir, acc, b_reg, psw;
    byte_t ram_data, rom_data;
    byte_t op_a, op_b, alu_res, alu_psw, psw_exec, sfr_rd;
    dir_t  dir;                     // direct address of the current access
    logic  access_hold;             // first cycle of an access, keep the bus

    function automatic byte_t operand(input src_e src);
        case (src)
            SRC_ACC:      return acc;
            SRC_RAM_DATA: return ram_data;
            SRC_ROM_DATA: return rom_data;
            SRC_PCH:      return pc[15:8];
            SRC_PCL:      return pc[7:0];
            default:      return 8'h00;
        endcase
    endfunction

    assign dir  = rom_data;
    assign op_a = operand(ctrl.exec_src_a);
    assign op_b = operand(ctrl.exec_src_b);

    cpu_alu u_alu (.op(ctrl.alu_op), .a(op_a), .b(op_b), .psw_in(psw),
                   .result(alu_res), .psw_out(alu_psw));

    always_comb begin
        psw_exec        = alu_psw;
        psw_exec[PSW_P] = ^alu_res;    // parity of the new accumulator
        case (dir)
            SFR_ACC: sfr_rd = acc;
            SFR_B:   sfr_rd = b_reg;
            SFR_PSW: sfr_rd = psw;
            default: sfr_rd = data_in;
        endcase
    end

    // ------------------------------------------------------------------------
    // program counter and bus address
    // ------------------------------------------------------------------------
    always_comb begin
        pc_d = pc;
        if (ctrl.state inside {ST_FETCH, ST_ROM_RD} && ctrl.capture)
            pc_d = pc + 16'd1;
        else if (ctrl.state == ST_EXEC && ctrl.exec_src_a == SRC_PCH)
            pc_d = {ram_data, rom_data};   // ljmp target
    end

    assign access_hold = !ctrl.capture &&
                         (ctrl.state inside {ST_FETCH, ST_ROM_RD, ST_RAM_RD, ST_RAM_WR});

    always_comb begin
        addr_d = addr_bus;
        if (ctrl.state == ST_DECODE)
            addr_d = (ctrl.exec_src_b == SRC_ROM_DATA) ? {8'h00, dir} : pc;
        else if (!access_hold)
            addr_d = pc_d;                 // next fetch address
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            ir       <= OP_NOP;
            acc      <= 8'h00;
            b_reg    <= 8'h00;
            psw      <= 8'h00;
            addr_bus <= RESET_PC;
        end else begin
            pc       <= pc_d;
            addr_bus <= addr_d;
            if (ctrl.state == ST_FETCH && ctrl.capture)
                ir <= data_in;
            if (ctrl.state == ST_EXEC && ctrl.exec_src_a == SRC_ACC) begin
                acc <= alu_res;
                psw <= psw_exec;
            end
            if (ctrl.state == ST_RAM_WR && ctrl.capture) begin
                case (dir)                 // sfr writes land here too
                    SFR_ACC: acc   <= data_out;
                    SFR_B:   b_reg <= data_out;
                    SFR_PSW: psw   <= data_out;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.state == ST_ROM_RD && ctrl.capture) begin
            if (ctrl.exec_src_a == SRC_RAM_DATA)
                ram_data <= data_in;       // ljmp high byte
            else
                rom_data <= data_in;
        end
        if (ctrl.state == ST_RAM_RD && ctrl.capture)
            ram_data <= sfr_rd;
        if (ctrl.state == ST_DECODE)
            data_out <= op_a;              // write data ready before the strobe
    end

    assign ctrl.instr = ir;

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.capture |-> $stable(addr_bus));

endmodule

//--- logic/cpu_pkg.sv
// cpu package
// shared widths, opcodes, special-function addresses and control encodings
// for the 8-bit 8051-style core

package cpu_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    typedef logic [7:0]  byte_t;   // data byte
    typedef logic [15:0] addr_t;   // bus address
    typedef logic [7:0]  dir_t;    // direct ram address
    typedef logic [3:0]  phase_t;  // remaining steps of an instruction

    localparam addr_t  RESET_PC   = 16'h0000;
    localparam phase_t NOP_CYCLES = 4'd6;   // idle count, state lasts one more

    // special-function registers served inside the core
    localparam dir_t SFR_ACC = 8'hE0;
    localparam dir_t SFR_B   = 8'hF0;
    localparam dir_t SFR_PSW = 8'hD0;

    // ------------------------------------------------------------------------
    // supported opcodes, anything else runs as nop
    // ------------------------------------------------------------------------
    localparam byte_t OP_NOP       = 8'h00;
    localparam byte_t OP_MOV_A_IMM = 8'h74;
    localparam byte_t OP_MOV_A_DIR = 8'hE5;
    localparam byte_t OP_MOV_DIR_A = 8'hF5;
    localparam byte_t OP_ADD_IMM   = 8'h24;
    localparam byte_t OP_ADD_DIR   = 8'h25;
    localparam byte_t OP_ANL_IMM   = 8'h54;
    localparam byte_t OP_ORL_IMM   = 8'h44;
    localparam byte_t OP_XRL_IMM   = 8'h64;
    localparam byte_t OP_INC_A     = 8'h04;
    localparam byte_t OP_DEC_A     = 8'h14;
    localparam byte_t OP_LJMP      = 8'h02;

    // psw flag positions
    localparam int PSW_CY = 7;
    localparam int PSW_AC = 6;
    localparam int PSW_OV = 2;
    localparam int PSW_P  = 0;

    // one-hot sequencer states
    typedef enum logic [6:0] {
        ST_NOP    = 7'b000_0001,
        ST_FETCH  = 7'b000_0010,
        ST_DECODE = 7'b000_0100,
        ST_RAM_RD = 7'b000_1000,
        ST_ROM_RD = 7'b001_0000,
        ST_EXEC   = 7'b010_0000,
        ST_RAM_WR = 7'b100_0000
    } cpu_state_e;

    // operand routing, also names the address source of an access step
    typedef enum logic [2:0] {
        SRC_ACC      = 3'd0,
        SRC_RAM_DATA = 3'd1,
        SRC_ROM_DATA = 3'd2,
        SRC_PCH      = 3'd3,
        SRC_PCL      = 3'd4,
        SRC_NONE     = 3'd7
    } src_e;

    typedef enum logic [2:0] {
        ALU_PASS_B, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_INC, ALU_DEC
    } alu_op_e;

endpackage

//--- logic/cpu_top.sv
// cpu top level
// sequencer and datapath joined by the control bundle, with the memory bus
// brought out as plain strobes and split data ports

`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t data_in,
    output addr_t addr_bus,
    output byte_t data_out,
    output logic  read_en,
    output logic  write_en,
    output logic  memory_select   // 1 ram, 0 rom
);

    cpu_ctrl_if ctrl_if ();

    cpu_control u_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl_if.cpu_control),
        .mem_rd  (read_en),
        .mem_wr  (write_en),
        .mem_sel (memory_select)
    );

    cpu_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_in  (data_in),
        .ctrl     (ctrl_if.cpu_datapath),
        .addr_bus (addr_bus),
        .data_out (data_out)
    );

endmodule

//--- logic/ins_decoder.sv
// instruction decoder
// maps opcode and remaining step count to the next state, operand routing
// and alu operation; steps count down, the highest number runs first

`timescale 1ns/100ps

module ins_decoder import cpu_pkg::*; (
    input  byte_t      instr,
    input  phase_t     run_phase,
    input  logic       first_decode,
    output phase_t     phase_init,
    output cpu_state_e next_state,
    output src_e       src_a,
    output src_e       src_b,
    output alu_op_e    alu_op
);

    phase_t  step;     // step the fields describe
    alu_op_e exec_op;  // operation of the execute step

    // number of steps per opcode
    always_comb begin
        case (instr)
            OP_MOV_A_IMM, OP_ADD_IMM, OP_ANL_IMM,
            OP_ORL_IMM, OP_XRL_IMM:     phase_init = 4'd2;
            OP_MOV_A_DIR, OP_ADD_DIR:   phase_init = 4'd3;
            OP_MOV_DIR_A:               phase_init = 4'd2;
            OP_INC_A, OP_DEC_A:         phase_init = 4'd1;
            OP_LJMP:                    phase_init = 4'd3;
            default:                    phase_init = 4'd0;
        endcase
    end

    assign step = first_decode ? phase_init : run_phase;

    always_comb begin
        case (instr)
            OP_ADD_IMM, OP_ADD_DIR: exec_op = ALU_ADD;
            OP_ANL_IMM:             exec_op = ALU_AND;
            OP_ORL_IMM:             exec_op = ALU_OR;
            OP_XRL_IMM:             exec_op = ALU_XOR;
            OP_INC_A:               exec_op = ALU_INC;
            OP_DEC_A:               exec_op = ALU_DEC;
            default:                exec_op = ALU_PASS_B;  // plain moves
        endcase
    end

    // ------------------------------------------------------------------------
    // step table
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = ST_NOP;
        src_a      = SRC_NONE;
        src_b      = SRC_NONE;
        alu_op     = exec_op;
        case (instr)
            OP_MOV_A_IMM, OP_ADD_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM: begin
                if (step == 4'd2) begin
                    next_state = ST_ROM_RD;       // immediate byte
                    src_a      = SRC_ROM_DATA;
                    src_b      = SRC_PCL;
                end else begin
                    next_state = ST_EXEC;
                    src_a      = SRC_ACC;
                    src_b      = SRC_ROM_DATA;
                end
            end
            OP_MOV_A_DIR, OP_ADD_DIR: begin
                case (step)
                    4'd3: begin
                        next_state = ST_ROM_RD;   // direct address
                        src_a      = SRC_ROM_DATA;
                        src_b      = SRC_PCL;
                    end
                    4'd2: begin
                        next_state = ST_RAM_RD;
                        src_a      = SRC_RAM_DATA;
                        src_b      = SRC_ROM_DATA;
                    end
                    default: begin
                        next_state = ST_EXEC;
                        src_a      = SRC_ACC;
                        src_b      = SRC_RAM_DATA;
                    end
                endcase
            end
            OP_MOV_DIR_A: begin
                next_state = (step == 4'd2) ? ST_ROM_RD : ST_RAM_WR;
                src_a      = (step == 4'd2) ? SRC_ROM_DATA : SRC_ACC;
                src_b      = (step == 4'd2) ? SRC_PCL : SRC_ROM_DATA;
            end
            OP_INC_A, OP_DEC_A: begin
                next_state = ST_EXEC;
                src_a      = SRC_ACC;
            end
            OP_LJMP: begin
                // high byte parks in ram data, low byte in rom data
                next_state = (step == 4'd1) ? ST_EXEC : ST_ROM_RD;
                src_a      = (step == 4'd3) ? SRC_RAM_DATA
                           : (step == 4'd2) ? SRC_ROM_DATA : SRC_PCH;
                src_b      = (step == 4'd1) ? SRC_NONE : SRC_PCL;
            end
            OP_NOP:  next_state = ST_NOP;
            default: next_state = ST_NOP;
        endcase
    end

endmodule

//--- project.f
logic/cpu_pkg.sv
logic/cpu_ctrl_if.sv
logic/cpu_alu.sv
logic/ins_decoder.sv
logic/cpu_control.sv
logic/cpu_datapath.sv
logic/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

//--- sim/cpu_checker.sv
// instruction-level reference model of the core
// predicts every bus access and compares it with the traffic on the bus

`timescale 1ns/100ps

module cpu_checker import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  read_en,
    input  logic  write_en,
    input  logic  memory_select,
    input  addr_t addr_bus,
    input  byte_t data_out,
    output logic  done,
    output int    value_errs,
    output int    other_errs
);

    localparam int K_ROM_RD = 0;
    localparam int K_RAM_RD = 1;
    localparam int K_RAM_WR = 2;

    byte_t m_rom [0:65535];
    byte_t m_ram [0:255];
    addr_t m_pc;
    byte_t m_acc, m_b, m_psw;
    int    loop_hits;
    int    exp_kind[$];
    addr_t exp_addr[$];
    byte_t exp_data[$];
    logic  rd_q, wr_q, seen_access;
    int    cycles;

    initial begin
        done        = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        rd_q        = 1'b0;
        wr_q        = 1'b0;
        seen_access = 1'b0;
        cycles      = 0;
        loop_hits   = 0;
        m_pc        = RESET_PC;
        m_acc       = 8'h00;
        m_b         = 8'h00;
        m_psw       = 8'h00;
        @(posedge rst_n);
        foreach (m_rom[i]) m_rom[i] = tb_cpu.rom[i];
        foreach (m_ram[i]) m_ram[i] = tb_cpu.ram[i];
    end

    task automatic expect_access(input int kind, input addr_t a, input byte_t d);
        exp_kind.push_back(kind);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    function automatic byte_t read_dir(input dir_t d);
        case (d)                                 // sfrs answer from inside the core
            SFR_ACC: return m_acc;
            SFR_B:   return m_b;
            SFR_PSW: return m_psw;
            default: return m_ram[d];
        endcase
    endfunction

    task automatic set_acc(input byte_t v);
        m_acc        = v;
        m_psw[PSW_P] = ($countones(v) % 2) == 1;   // odd number of ones
    endtask

    task automatic add_acc(input byte_t v);
        logic [8:0] sum;
        int         ssum;   // signed sum for the overflow range
        sum           = {1'b0, m_acc} + {1'b0, v};
        ssum          = int'($signed(m_acc)) + int'($signed(v));
        m_psw[PSW_CY] = sum[8];
        m_psw[PSW_AC] = ({1'b0, m_acc[3:0]} + {1'b0, v[3:0]}) > 5'd15;
        m_psw[PSW_OV] = (ssum > 127) || (ssum < -128);
        set_acc(sum[7:0]);
    endtask

    // ------------------------------------------------------------------------
    // one instruction, queueing its accesses
    // ------------------------------------------------------------------------
    task automatic step_model();
        byte_t op, opnd;
        addr_t target;
        op   = m_rom[m_pc];
        opnd = m_rom[m_pc + 16'd1];
        expect_access(K_ROM_RD, m_pc, 8'h00);
        case (op)
            OP_MOV_A_IMM, OP_ADD_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM: begin
                expect_access(K_ROM_RD, m_pc + 16'd1, 8'h00);
                case (op)
                    OP_MOV_A_IMM: set_acc(opnd);
                    OP_ADD_IMM:   add_acc(opnd);
                    OP_ANL_IMM:   set_acc(m_acc & opnd);
                    OP_ORL_IMM:   set_acc(m_acc | opnd);
                    default:      set_acc(m_acc ^ opnd);
                endcase
                m_pc = m_pc + 16'd2;
            end
            OP_MOV_A_DIR, OP_ADD_DIR: begin
                expect_access(K_ROM_RD, m_pc + 16'd1, 8'h00);
                expect_access(K_RAM_RD, {8'h00, opnd}, 8'h00);
                if (op == OP_ADD_DIR)
                    add_acc(read_dir(opnd));
                else
                    set_acc(read_dir(opnd));
                m_pc = m_pc + 16'd2;
            end
            OP_MOV_DIR_A: begin
                expect_access(K_ROM_RD, m_pc + 16'd1, 8'h00);
                expect_access(K_RAM_WR, {8'h00, opnd}, m_acc);
                m_ram[opnd] = m_acc;
                if (opnd == SFR_B)   m_b   = m_acc;
                if (opnd == SFR_PSW) m_psw = m_acc;   // no parity update here
                m_pc = m_pc + 16'd2;
            end
            OP_INC_A: begin
                set_acc(m_acc + 8'd1);
                m_pc = m_pc + 16'd1;
            end
            OP_DEC_A: begin
                set_acc(m_acc - 8'd1);
                m_pc = m_pc + 16'd1;
            end
            OP_LJMP: begin
                expect_access(K_ROM_RD, m_pc + 16'd1, 8'h00);
                expect_access(K_ROM_RD, m_pc + 16'd2, 8'h00);
                target = {opnd, m_rom[m_pc + 16'd2]};
                if (target == m_pc) begin
                    loop_hits++;
                    if (loop_hits >= 3) done = 1'b1;
                end
                m_pc = target;
            end
            default: m_pc = m_pc + 16'd1;    // nop and unused opcodes
        endcase
    endtask

    task automatic check_access(input logic is_wr);
        int got_kind;
        got_kind = is_wr ? K_RAM_WR : (memory_select ? K_RAM_RD : K_ROM_RD);
        if (exp_kind.size() == 0)
            step_model();
        if (got_kind != exp_kind[0]) begin
            $display("at %0t the bus access kind was %0d where %0d was expected",
                     $time, got_kind, exp_kind[0]);
            other_errs++;
        end
        if (addr_bus != exp_addr[0]) begin
            $display("ERR %0t addr_bus exp %h got %h", $time, exp_addr[0], addr_bus);
            value_errs++;
        end
        if (got_kind == K_RAM_WR && data_out != exp_data[0]) begin
            $display("ERR %0t data_out exp %h got %h", $time, exp_data[0], data_out);
            value_errs++;
        end
        void'(exp_kind.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
    endtask

    always @(negedge clk) begin
        if (rst_n && !done) begin
            if (read_en && write_en) begin
                $display("at %0t read and write strobes were high together", $time);
                other_errs++;
            end
            // idle after reset lasts one cycle longer than the nop count
            if (!seen_access && (read_en || write_en) &&
                cycles < int'(NOP_CYCLES) + 1) begin
                $display("at %0t a strobe rose before the reset idle ended", $time);
                other_errs++;
            end
            if ((read_en && !rd_q) || (write_en && !wr_q)) begin
                seen_access = 1'b1;
                check_access(write_en);
            end
            cycles++;
            rd_q = read_en;
            wr_q = write_en;
        end
    end

endmodule

//--- sim/tb_cpu.sv
// testbench top for the 8-bit core
// clock, reset, random program and ram images, rom/ram bus models and watchdog

`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*;;

    localparam logic [31:0] SEED       = 32'hca526c3e;
    localparam int          PROG_LEN   = 150;
    localparam int          CLK_PERIOD = 40;
    localparam int          TIMEOUT_CYC = PROG_LEN * 20 + 200;   // worst case plus margin

    logic  clk;
    logic  rst_n;
    byte_t data_in;
    addr_t addr_bus;
    byte_t data_out;
    logic  read_en;
    logic  write_en;
    logic  memory_select;
    logic  done;
    int    value_errs;
    int    other_errs;

    byte_t       rom [0:65535];
    byte_t       ram [0:255];
    logic [31:0] rng_state;
    addr_t       wr_ptr;

    cpu_top uut (.clk(clk), .rst_n(rst_n), .data_in(data_in), .addr_bus(addr_bus),
                 .data_out(data_out), .read_en(read_en), .write_en(write_en),
                 .memory_select(memory_select));

    cpu_checker chk (.clk(clk), .rst_n(rst_n), .read_en(read_en), .write_en(write_en),
                     .memory_select(memory_select), .addr_bus(addr_bus),
                     .data_out(data_out), .done(done), .value_errs(value_errs),
                     .other_errs(other_errs));

    // ------------------------------------------------------------------------
    // memory models
    // ------------------------------------------------------------------------
    assign data_in = !read_en ? 8'h00 : (memory_select ? ram[addr_bus[7:0]] : rom[addr_bus]);

    always @(posedge clk) begin
        if (write_en && memory_select)
            ram[addr_bus[7:0]] <= data_out;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic dir_t pick_dir();
        logic [31:0] r;
        r = lcg_next();
        if (r[31:30] != 2'b00)
            return {2'b00, r[21:16]};          // plain ram 00-3f
        case (r[29:28])
            2'd0:    return SFR_ACC;
            2'd1:    return SFR_B;
            default: return SFR_PSW;
        endcase
    endfunction

    function automatic logic is_known(input byte_t op);
        return op inside {OP_NOP, OP_MOV_A_IMM, OP_MOV_A_DIR, OP_MOV_DIR_A, OP_ADD_IMM,
                          OP_ADD_DIR, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM, OP_INC_A,
                          OP_DEC_A, OP_LJMP};
    endfunction

    task automatic put_byte(input byte_t v);
        rom[wr_ptr] = v;
        wr_ptr      = wr_ptr + 16'd1;
    endtask

    // opcode followed by its one operand byte
    task automatic put_op_arg(input byte_t op, input byte_t arg);
        put_byte(op);
        put_byte(arg);
    endtask

    task automatic build_images();
        logic [31:0] r;
        logic [31:0] imm;
        addr_t       target;
        for (int i = 0; i < 65536; i++) begin
            r      = lcg_next();
            rom[i] = r[23:16];
        end
        for (int i = 0; i < 256; i++) begin
            r      = lcg_next();
            ram[i] = r[23:16];
        end
        wr_ptr = RESET_PC;
        for (int n = 0; n < PROG_LEN; n++) begin
            r   = lcg_next();
            imm = lcg_next();
            case (r[31:28])
                4'd0:  put_byte(OP_NOP);
                4'd1:  put_byte(is_known(r[7:0]) ? 8'hA5 : r[7:0]);   // unused opcode
                4'd2:  put_op_arg(OP_MOV_A_IMM, imm[15:8]);
                4'd3:  put_op_arg(OP_MOV_A_DIR, pick_dir());
                4'd4, 4'd5: put_op_arg(OP_MOV_DIR_A, pick_dir());
                4'd6, 4'd15: put_op_arg(OP_ADD_IMM, imm[15:8]);
                4'd7:  put_op_arg(OP_ADD_DIR, pick_dir());
                4'd8:  put_op_arg(OP_ANL_IMM, imm[15:8]);
                4'd9:  put_op_arg(OP_ORL_IMM, imm[15:8]);
                4'd10: put_op_arg(OP_XRL_IMM, imm[15:8]);
                4'd11: put_byte(OP_INC_A);
                4'd12: put_byte(OP_DEC_A);
                4'd13: begin
                    // forward jump over a few garbage bytes
                    target = wr_ptr + 16'd3 + {13'd0, r[2:0]};
                    put_byte(OP_LJMP);
                    put_byte(target[15:8]);
                    put_byte(target[7:0]);
                    wr_ptr = target;
                end
                default: begin
                    put_op_arg(OP_MOV_A_DIR, SFR_PSW);    // psw snapshot, then store it
                    put_op_arg(OP_MOV_DIR_A, {2'b00, imm[13:8]});
                end
            endcase
        end
        target = wr_ptr;                              // final self loop
        put_byte(OP_LJMP);
        put_byte(target[15:8]);
        put_byte(target[7:0]);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n     = 1'b0;
        rng_state = SEED;
        build_images();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait (done);
        repeat (2) @(posedge clk);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: the program did not reach its final loop in %0d cycles",
                 TIMEOUT_CYC);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
